/* all.f */
+incdir+.
adc_fifo_pkg.sv
sample_fifo.sv
adc_sample_capture.sv
reg_adc_fifo.sv
adc_fifo_top.sv
adc_fifo_chk.sv
tb_adc_fifo.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_adc_fifo
RTL_TOP   ?= adc_fifo_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_adc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_fifo_consts.svh"

module tb_adc_fifo;
   import adc_fifo_pkg::*;

   localparam int MAX_CYCLES = 3000;   // Several times the full run
   localparam int FIFO_BYTES = 1 << `FIFO_DEPTH_LOG2;

   logic                      clk_usb;
   logic                      reset;
   reg_addr_t                 reg_address;
   logic [`BYTECNT_WIDTH-1:0] reg_bytecnt;
   fifo_byte_t                reg_datai;
   fifo_byte_t                reg_datao;
   logic                      reg_read;
   logic                      reg_write;
   logic                      adc_valid;
   adc_sample_t               adc_data;

   fifo_byte_t expected_q[$];   // Bytes the host should see, in order
   fifo_byte_t rdata;
   int         errors = 0;
   int         checks = 0;
   int         cycles = 0;
   int         seed;

   adc_fifo_top UUT (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .reg_address (reg_address),
      .reg_bytecnt (reg_bytecnt),
      .reg_datai   (reg_datai),
      .reg_datao   (reg_datao),
      .reg_read    (reg_read),
      .reg_write   (reg_write),
      .adc_valid   (adc_valid),
      .adc_data    (adc_data)
   );

   bind adc_fifo_top adc_fifo_chk chk (
      .clk_usb      (clk_usb),
      .reset        (reset),
      .arm          (arm),
      .clear_errors (clear_errors),
      .wr_en        (wr_en),
      .fifo_rd_en   (fifo_rd_en),
      .capture_done (capture_done),
      .overflow     (overflow)
   );

   initial begin
      clk_usb = 1'b0;
      forever #50 clk_usb = ~clk_usb;
   end

   always @(posedge clk_usb) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles, errors so far %0d",
                  MAX_CYCLES, errors);
         $display("Regression failed");
         $finish;
      end
   end

   task automatic write_reg(input reg_addr_t addr, input int bytecnt, input fifo_byte_t data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= bytecnt[`BYTECNT_WIDTH-1:0];
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge clk_usb);
      reg_write <= 1'b0;
   endtask

   // Two-cycle read with data taken in the first cycle
   task automatic read_reg(input reg_addr_t addr, input int bytecnt, output fifo_byte_t data);
      @(posedge clk_usb);
      reg_address <= addr;
      reg_bytecnt <= bytecnt[`BYTECNT_WIDTH-1:0];
      reg_read    <= 1'b1;
      @(negedge clk_usb);
      data = reg_datao;
      @(posedge clk_usb);
      @(posedge clk_usb);
      reg_read <= 1'b0;
   endtask

   task automatic check_equal(input string name, input fifo_byte_t got, input fifo_byte_t exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
      end
   endtask

   task automatic expect_reg(input reg_addr_t addr, input int bytecnt, input fifo_byte_t exp);
      fifo_byte_t got;
      read_reg(addr, bytecnt, got);
      check_equal($sformatf("reg_datao[0x%02h/%0d]", addr, bytecnt), got, exp);
   endtask

   // Bytes past the FIFO size are dropped by the DUT
   function automatic void push_byte(input fifo_byte_t b);
      if (expected_q.size() < FIFO_BYTES)
         expected_q.push_back(b);
   endfunction

   function automatic void queue_sample_bytes(input adc_sample_t s, input bit low);
      if (low) begin
         push_byte(s[9:2]);
      end else begin
         push_byte({6'b000000, s[9:8]});   // High byte first
         push_byte(s[7:0]);
      end
   endfunction

   // Strobes three cycles apart with only the first ones captured
   task automatic send_samples(input int accepted, input int total, input bit low);
      int          rnd;
      adc_sample_t s;
      for (int i = 0; i < total; i++) begin
         rnd = $random(seed);
         s   = rnd[9:0];
         if (i < accepted)
            queue_sample_bytes(s, low);
         @(posedge clk_usb);
         adc_valid <= 1'b1;
         adc_data  <= s;
         @(posedge clk_usb);
         adc_valid <= 1'b0;
         @(posedge clk_usb);
      end
   endtask

   task automatic wait_capture_done();
      fifo_byte_t st;
      int         tries;
      tries = 0;
      st    = 8'h00;
      while (st[0] !== 1'b1 && tries < 20) begin
         read_reg(`CAPTURE_CTRL, 0, st);
         tries++;
      end
      checks++;
      assert (st[0] === 1'b1) else begin
         errors++;
         $display("Capture did not report done after %0d status reads", tries);
      end
   endtask

   task automatic read_expected_bytes();
      fifo_byte_t got;
      while (expected_q.size() > 0) begin
         read_reg(`ADCREAD_ADDR, 0, got);
         check_equal("reg_datao[ADCREAD]", got, expected_q.pop_front());
      end
   endtask

   initial begin
      seed        = 460;
      reset       = 1'b1;
      reg_address = 8'h00;
      reg_bytecnt = '0;
      reg_datai   = 8'h00;
      reg_read    = 1'b0;
      reg_write   = 1'b0;
      adc_valid   = 1'b0;
      adc_data    = '0;
      repeat (5) @(posedge clk_usb);
      reset <= 1'b0;

      // Reset values
      expect_reg(`FIFO_STAT, 0, 8'h01);
      expect_reg(`FIFO_STATE, 0, 8'h00);
      expect_reg(`ADC_LOW_RES, 0, 8'h00);
      expect_reg(`SEGMENT_SAMPLES, 0, 8'h10);
      expect_reg(`SEGMENT_SAMPLES, 1, 8'h00);
      expect_reg(`CAPTURE_CTRL, 0, 8'h00);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h00);
      expect_reg(`FAST_FIFO_READ_MODE, 0, 8'h00);

      // Normal mode with 4 samples and two late ones
      write_reg(`SEGMENT_SAMPLES, 0, 8'h04);
      write_reg(`CAPTURE_CTRL, 0, 8'h01);
      send_samples(4, 6, 1'b0);
      wait_capture_done();
      expect_reg(`FIFO_STATE, 0, 8'h03);
      read_expected_bytes();
      expect_reg(`FIFO_STAT, 0, 8'h01);
      read_reg(`ADCREAD_ADDR, 0, rdata);   // Only the underflow count moves
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h01);
      expect_reg(`FIFO_STAT, 0, 8'h01);

      // Low resolution with the count written over two bytes
      write_reg(`ADC_LOW_RES, 0, 8'h01);
      write_reg(`SEGMENT_SAMPLES, 0, 8'h05);
      write_reg(`SEGMENT_SAMPLES, 1, 8'h00);
      expect_reg(`ADC_LOW_RES, 0, 8'h01);
      expect_reg(`SEGMENT_SAMPLES, 0, 8'h05);
      expect_reg(`SEGMENT_SAMPLES, 1, 8'h00);
      write_reg(`CAPTURE_CTRL, 0, 8'h01);
      send_samples(5, 7, 1'b1);
      wait_capture_done();
      read_expected_bytes();
      expect_reg(`FIFO_STAT, 0, 8'h01);

      // Fast read mode set after the capture since the arm write clears it
      write_reg(`ADC_LOW_RES, 0, 8'h00);
      write_reg(`SEGMENT_SAMPLES, 0, 8'h03);
      write_reg(`CAPTURE_CTRL, 0, 8'h01);
      send_samples(3, 3, 1'b0);
      wait_capture_done();
      write_reg(`FAST_FIFO_READ_MODE, 0, 8'h01);
      expect_reg(`FAST_FIFO_READ_MODE, 0, 8'h01);
      read_expected_bytes();
      expect_reg(`FIFO_STAT, 0, 8'h01);
      write_reg(`ADC_LOW_RES, 0, 8'h00);
      expect_reg(`FAST_FIFO_READ_MODE, 0, 8'h00);

      // Underflow and then overflow with 40 bytes into 32
      write_reg(`FIFO_STAT, 0, 8'h01);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h00);
      repeat (3) read_reg(`ADCREAD_ADDR, 0, rdata);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h03);
      write_reg(`SEGMENT_SAMPLES, 0, 8'h14);
      write_reg(`CAPTURE_CTRL, 0, 8'h01);
      send_samples(20, 20, 1'b0);
      wait_capture_done();
      expect_reg(`FIFO_STAT, 0, 8'h02);
      read_expected_bytes();
      expect_reg(`FIFO_STAT, 0, 8'h03);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h03);
      write_reg(`FIFO_STAT, 0, 8'h01);
      expect_reg(`FIFO_STAT, 0, 8'h01);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 0, 8'h00);

      errors += UUT.chk.fail_count;
      $display("Checks: %0d  Errors: %0d", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* adc_fifo_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_fifo_chk (
   input wire clk_usb,
   input wire reset,
   input wire arm,
   input wire clear_errors,
   input wire wr_en,
   input wire fifo_rd_en,
   input wire capture_done,
   input wire overflow
);

   int   rd_fails = 0;
   int   wr_fails = 0;
   int   rst_fails = 0;
   int   fail_count;
   logic reset_d;   // Reset one cycle late

   assign fail_count = rd_fails + wr_fails + rst_fails;

   always_ff @(posedge clk_usb)
      reset_d <= reset;

   // One pop per host read in either mode
   rd_pulse: assert property (@(posedge clk_usb) disable iff (reset)
      fifo_rd_en |=> !fifo_rd_en)
      else begin
         rd_fails = rd_fails + 1;
         $error("fifo_rd_en high in two consecutive cycles");
      end

   // At most high byte then low byte
   wr_burst: assert property (@(posedge clk_usb) disable iff (reset)
      (wr_en && $past(wr_en)) |=> !wr_en)
      else begin
         wr_fails = wr_fails + 1;
         $error("wr_en high for more than two cycles");
      end

   reset_quiet: assert property (@(posedge clk_usb)
      reset_d |-> (!arm && !clear_errors && !wr_en && !fifo_rd_en &&
                   !capture_done && !overflow))
      else begin
         rst_fails = rst_fails + 1;
         $error("Control output high in the cycle after reset");
      end

endmodule

`default_nettype wire

/* adc_fifo_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_fifo_consts.svh"

module adc_fifo_top (
   input  wire                             clk_usb,
   input  wire                             reset,
   input  wire adc_fifo_pkg::reg_addr_t    reg_address,
   input  wire [`BYTECNT_WIDTH-1:0]        reg_bytecnt,
   input  wire adc_fifo_pkg::fifo_byte_t   reg_datai,
   output wire adc_fifo_pkg::fifo_byte_t   reg_datao,
   input  wire                             reg_read,
   input  wire                             reg_write,
   input  wire                             adc_valid,
   input  wire adc_fifo_pkg::adc_sample_t  adc_data
);
   import adc_fifo_pkg::*;

   // Register block to capture and FIFO
   wire             arm;
   wire             low_res;
   wire seg_count_t segment_samples;
   wire             clear_errors;
   wire             fifo_rd_en;

   // Capture to FIFO and status
   wire                 wr_en;
   wire fifo_byte_t     wr_data;
   wire capture_state_t capture_state;
   wire                 capture_done;

   // FIFO status and head byte
   wire fifo_byte_t rd_data;
   wire             empty;
   wire             overflow;
   wire fifo_byte_t underflow_count;

   adc_sample_capture U_capture (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .arm             (arm),
      .low_res         (low_res),
      .segment_samples (segment_samples),
      .adc_valid       (adc_valid),
      .adc_data        (adc_data),
      .wr_en           (wr_en),
      .wr_data         (wr_data),
      .capture_state   (capture_state),
      .capture_done    (capture_done)
   );

   sample_fifo U_fifo (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .wr_en           (wr_en),
      .wr_data         (wr_data),
      .rd_en           (fifo_rd_en),
      .clear_errors    (clear_errors),
      .rd_data         (rd_data),
      .empty           (empty),
      .full            (),              // Only used inside the FIFO
      .overflow        (overflow),
      .underflow_count (underflow_count)
   );

   reg_adc_fifo U_regs (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_address     (reg_address),
      .reg_bytecnt     (reg_bytecnt),
      .reg_datai       (reg_datai),
      .reg_read        (reg_read),
      .reg_write       (reg_write),
      .capture_state   (capture_state),
      .capture_done    (capture_done),
      .fifo_data       (rd_data),
      .fifo_empty      (empty),
      .fifo_overflow   (overflow),
      .underflow_count (underflow_count),
      .reg_datao       (reg_datao),
      .fifo_rd_en      (fifo_rd_en),
      .arm             (arm),
      .low_res         (low_res),
      .segment_samples (segment_samples),
      .clear_errors    (clear_errors)
   );

endmodule

`default_nettype wire

/* reg_adc_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_fifo_consts.svh"

module reg_adc_fifo (
   input  wire                                clk_usb,
   input  wire                                reset,
   input  wire adc_fifo_pkg::reg_addr_t       reg_address,
   input  wire [`BYTECNT_WIDTH-1:0]           reg_bytecnt,     // Byte within the register
   input  wire adc_fifo_pkg::fifo_byte_t      reg_datai,
   input  wire                                reg_read,        // Level for the whole read
   input  wire                                reg_write,       // One-cycle strobe
   input  wire adc_fifo_pkg::capture_state_t  capture_state,
   input  wire                                capture_done,
   input  wire adc_fifo_pkg::fifo_byte_t      fifo_data,
   input  wire                                fifo_empty,
   input  wire                                fifo_overflow,
   input  wire adc_fifo_pkg::fifo_byte_t      underflow_count,
   output adc_fifo_pkg::fifo_byte_t           reg_datao,
   output logic                               fifo_rd_en,
   output logic                               arm,
   output logic                               low_res,
   output adc_fifo_pkg::seg_count_t           segment_samples,
   output logic                               clear_errors
);
   import adc_fifo_pkg::*;

   logic       fast_fifo_read_mode;
   logic       reg_read_r;        // reg_read one cycle late
   logic       fifo_rd_en_reg;
   logic       adc_read_start;
   fifo_byte_t seg_byte;

   // First cycle of a read at the ADC data address
   assign adc_read_start = reg_read && !reg_read_r && (reg_address == `ADCREAD_ADDR);

   // Fast mode pops in the same cycle, normal mode one cycle later
   assign fifo_rd_en = fast_fifo_read_mode ? adc_read_start : fifo_rd_en_reg;

   // Sample count has bytes 0 and 1 only
   assign seg_byte = (reg_bytecnt > 1) ? 8'h00 :
                     segment_samples[{reg_bytecnt[0], 3'b000} +: 8];

   always_comb begin
      if (reg_read) begin
         case (reg_address)
            `FIFO_STAT:            reg_datao = {6'b000000, fifo_overflow, fifo_empty};
            `FIFO_STATE:           reg_datao = {6'b000000, capture_state};
            `ADC_LOW_RES:          reg_datao = {7'b0000000, low_res};
            `SEGMENT_SAMPLES:      reg_datao = seg_byte;
            `CAPTURE_CTRL:         reg_datao = {7'b0000000, capture_done};
            `FIFO_UNDERFLOW_COUNT: reg_datao = underflow_count;
            `FAST_FIFO_READ_MODE:  reg_datao = {7'b0000000, fast_fifo_read_mode};
            `ADCREAD_ADDR:         reg_datao = fifo_data;
            default:               reg_datao = 8'h00;
         endcase
      end else begin
         reg_datao = 8'h00;
      end
   end

   // Configuration and one-cycle pulses
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         low_res         <= 1'b0;
         segment_samples <= `DEFAULT_SEGMENT_SAMPLES;
         arm             <= 1'b0;
         clear_errors    <= 1'b0;
      end else begin
         arm          <= 1'b0;
         clear_errors <= 1'b0;
         if (reg_write) begin
            case (reg_address)
               `FIFO_STAT:    clear_errors <= reg_datai[0];
               `ADC_LOW_RES:  low_res <= reg_datai[0];
               `CAPTURE_CTRL: arm <= reg_datai[0];
               `SEGMENT_SAMPLES: begin
                  if (reg_bytecnt < 2)
                     segment_samples[{reg_bytecnt[0], 3'b000} +: 8] <= reg_datai;
               end
               default: ;
            endcase
         end
      end
   end

   // Any write elsewhere drops out of fast mode
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         fast_fifo_read_mode <= 1'b0;
      end else if (reg_write) begin
         if (reg_address == `FAST_FIFO_READ_MODE)
            fast_fifo_read_mode <= reg_datai[0];
         else
            fast_fifo_read_mode <= 1'b0;
      end
   end

   // Read edge detect and registered pop
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_read_r     <= 1'b0;
         fifo_rd_en_reg <= 1'b0;
      end else begin
         reg_read_r     <= reg_read;
         fifo_rd_en_reg <= adc_read_start && !fast_fifo_read_mode;
      end
   end

endmodule

`default_nettype wire

/* adc_sample_capture.sv */
`timescale 1ns/1ns
`default_nettype none

module adc_sample_capture (
   input  wire                             clk_usb,
   input  wire                             reset,
   input  wire                             arm,               // One-cycle start pulse
   input  wire                             low_res,           // One byte per sample
   input  wire adc_fifo_pkg::seg_count_t   segment_samples,
   input  wire                             adc_valid,
   input  wire adc_fifo_pkg::adc_sample_t  adc_data,
   output logic                            wr_en,
   output adc_fifo_pkg::fifo_byte_t        wr_data,
   output adc_fifo_pkg::capture_state_t    capture_state,
   output logic                            capture_done
);
   import adc_fifo_pkg::*;

   seg_count_t sample_count;   // Samples accepted since arm
   seg_count_t count_next;
   fifo_byte_t low_byte;       // Held for the second write
   logic       take_sample;

   assign take_sample  = (capture_state == CAP_WAIT) && adc_valid;
   assign count_next   = sample_count + 1'b1;
   assign capture_done = (capture_state == CAP_DONE);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         capture_state <= CAP_IDLE;
         sample_count  <= '0;
         wr_en         <= 1'b0;
      end else begin
         wr_en <= 1'b0;
         case (capture_state)
            CAP_IDLE, CAP_DONE: begin
               if (arm) begin
                  capture_state <= CAP_WAIT;
                  sample_count  <= '0;
               end
            end
            CAP_WAIT: begin
               if (adc_valid) begin
                  wr_en        <= 1'b1;   // First byte goes out now
                  sample_count <= count_next;
                  if (!low_res)
                     capture_state <= CAP_LOW_BYTE;
                  else if (count_next >= segment_samples)
                     capture_state <= CAP_DONE;
               end
            end
            CAP_LOW_BYTE: begin
               // Strobes here are dropped
               wr_en         <= 1'b1;
               capture_state <= (sample_count >= segment_samples) ? CAP_DONE : CAP_WAIT;
            end
            default: capture_state <= CAP_IDLE;
         endcase
      end
   end

   // Byte conversion
   always_ff @(posedge clk_usb) begin
      if (take_sample) begin
         if (low_res) begin
            wr_data <= adc_data[9:2];
         end else begin
            wr_data  <= {6'b000000, adc_data[9:8]};   // High byte first
            low_byte <= adc_data[7:0];
         end
      end else if (capture_state == CAP_LOW_BYTE) begin
         wr_data <= low_byte;
      end
   end

endmodule

`default_nettype wire

/* sample_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "adc_fifo_consts.svh"

module sample_fifo #(
   parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
   input  wire                             clk_usb,
   input  wire                             reset,
   input  wire                             wr_en,
   input  wire adc_fifo_pkg::fifo_byte_t   wr_data,
   input  wire                             rd_en,
   input  wire                             clear_errors,
   output adc_fifo_pkg::fifo_byte_t        rd_data,
   output logic                            empty,
   output logic                            full,
   output logic                            overflow,          // Sticky
   output adc_fifo_pkg::fifo_byte_t        underflow_count
);
   import adc_fifo_pkg::*;

   localparam int DEPTH = 1 << DEPTH_LOG2;

   fifo_byte_t          mem [DEPTH];
   logic [DEPTH_LOG2:0] wr_ptr;   // MSB is the wrap bit
   logic [DEPTH_LOG2:0] rd_ptr;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

   // Head byte without read latency
   assign rd_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge clk_usb) begin
      if (wr_en && !full)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         overflow        <= 1'b0;
         underflow_count <= '0;
      end else begin
         if (wr_en && !full)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en && !empty)
            rd_ptr <= rd_ptr + 1'b1;

         if (clear_errors) begin
            overflow        <= 1'b0;
            underflow_count <= '0;
         end else begin
            if (wr_en && full)
               overflow <= 1'b1;   // Byte is dropped
            if (rd_en && empty && (underflow_count != 8'hFF))
               underflow_count <= underflow_count + 1'b1;   // Saturates
         end
      end
   end

endmodule

`default_nettype wire

/* adc_fifo_pkg.sv */
`default_nettype none

package adc_fifo_pkg;

   typedef logic [9:0]  adc_sample_t;   // Raw ADC sample
   typedef logic [7:0]  fifo_byte_t;    // FIFO entry and register byte
   typedef logic [7:0]  reg_addr_t;     // Host register address
   typedef logic [15:0] seg_count_t;    // Samples per capture

   // Capture sequencing as read through FIFO_STATE
   typedef enum logic [1:0] {
      CAP_IDLE     = 2'd0,   // Not armed
      CAP_WAIT     = 2'd1,   // Armed and waiting for a sample
      CAP_LOW_BYTE = 2'd2,   // Second byte pending
      CAP_DONE     = 2'd3    // Sample count reached
   } capture_state_t;

endpackage

`default_nettype wire

/* adc_fifo_consts.svh */
`ifndef ADC_FIFO_CONSTS_SVH
`define ADC_FIFO_CONSTS_SVH

// Host register map
`define ADCREAD_ADDR          8'h03
`define FIFO_STAT             8'h06
`define FIFO_STATE            8'h07
`define ADC_LOW_RES           8'h08
`define SEGMENT_SAMPLES       8'h09
`define CAPTURE_CTRL          8'h0A
`define FIFO_UNDERFLOW_COUNT  8'h0B
`define FAST_FIFO_READ_MODE   8'h0C

// Width of the byte index within a multi-byte register
`define BYTECNT_WIDTH         2

// 32 byte FIFO
`define FIFO_DEPTH_LOG2       5

// Samples per capture after reset
`define DEFAULT_SEGMENT_SAMPLES 16'd16

`endif
